// File: files.f
rtl/pss_pkg.sv
rtl/pss_correlator.sv
rtl/pss_decision.sv
rtl/detect_fifo.sv
rtl/pss_regs.sv
rtl/pss_detector_top.sv
testbench/pss_detector_assert.sv
testbench/pss_detector_tb.sv

// File: rtl/detect_fifo.sv
`timescale 1ns/10ps

module detect_fifo import pss_pkg::*; #(
    parameter int FIFO_DEPTH = DEFAULT_FIFO_DEPTH
) (
    input  logic                              clk_i,
    input  logic                              reset_ni,
    input  logic                              push_i,
    input  detect_t                           data_i,
    input  logic                              pop_i,
    output detect_t                           data_o,
    output logic [$clog2(FIFO_DEPTH+1)-1:0]   level_o,
    output logic                              overflow_o,
    input  logic                              clear_overflow_i
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int LEVEL_W = $clog2(FIFO_DEPTH + 1);

    detect_t mem_q [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [LEVEL_W-1:0] level_q;
    logic full;
    logic do_push;
    logic do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full = (level_q == LEVEL_W'(FIFO_DEPTH));
    assign do_push = push_i && !full;
    assign do_pop = pop_i && (level_q != '0);

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            level_q <= '0;
            overflow_o <= 1'b0;
        end else begin
            if (do_push) wr_ptr_q <= next_ptr(wr_ptr_q);
            if (do_pop) rd_ptr_q <= next_ptr(rd_ptr_q);
            case ({do_push, do_pop})
                2'b10: level_q <= level_q + 1'b1;
                2'b01: level_q <= level_q - 1'b1;
                default: level_q <= level_q;
            endcase
            // a new drop wins over a clear in the same cycle
            if (push_i && full) begin
                overflow_o <= 1'b1;
            end else if (clear_overflow_i) begin
                overflow_o <= 1'b0;
            end
        end
    end

    // first word fall through
    assign data_o = mem_q[rd_ptr_q];
    assign level_o = level_q;

endmodule

// File: rtl/pss_correlator.sv
`timescale 1ns/10ps

module pss_correlator import pss_pkg::*; #(
    parameter int PSS_LEN = DEFAULT_PSS_LEN,
    parameter int N_ID_2 = 0
) (
    input  logic    clk_i,
    input  logic    reset_ni,
    input  sample_t sample_i_i,
    input  sample_t sample_q_i,
    input  logic    sample_valid_i,
    input  logic    corr_en_i,
    input  corr_t   threshold_i,
    output logic    peak_o
);

    // one sign bit plus growth over PSS_LEN terms
    localparam int SUM_W = $bits(sample_t) + $clog2(PSS_LEN) + 1;
    localparam logic [31:0] TAPS = (N_ID_2 == 0) ? PSS_TAPS_0 :
                                   (N_ID_2 == 1) ? PSS_TAPS_1 : PSS_TAPS_2;

    // line_*_q[0] holds the oldest sample
    sample_t line_i_q [PSS_LEN];
    sample_t line_q_q [PSS_LEN];
    logic shifted_q;
    logic accept;
    logic signed [SUM_W-1:0] sum_i;
    logic signed [SUM_W-1:0] sum_q;
    logic [SUM_W-1:0] abs_i;
    logic [SUM_W-1:0] abs_q;
    corr_t magnitude;

    assign accept = sample_valid_i && corr_en_i;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            for (int j = 0; j < PSS_LEN; j++) begin
                line_i_q[j] <= '0;
                line_q_q[j] <= '0;
            end
        end else if (accept) begin
            for (int j = 0; j < PSS_LEN - 1; j++) begin
                line_i_q[j] <= line_i_q[j+1];
                line_q_q[j] <= line_q_q[j+1];
            end
            line_i_q[PSS_LEN-1] <= sample_i_i;
            line_q_q[PSS_LEN-1] <= sample_q_i;
        end
    end

    // signed sum with +-1 taps
    always_comb begin
        sum_i = '0;
        sum_q = '0;
        for (int j = 0; j < PSS_LEN; j++) begin
            if (TAPS[j]) begin
                sum_i = sum_i + line_i_q[j];
                sum_q = sum_q + line_q_q[j];
            end else begin
                sum_i = sum_i - line_i_q[j];
                sum_q = sum_q - line_q_q[j];
            end
        end
    end

    assign abs_i = sum_i[SUM_W-1] ? -sum_i : sum_i;
    assign abs_q = sum_q[SUM_W-1] ? -sum_q : sum_q;
    assign magnitude = corr_t'(abs_i) + corr_t'(abs_q);

    // compare only on the cycle after a new sample entered the line
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            shifted_q <= 1'b0;
            peak_o <= 1'b0;
        end else begin
            shifted_q <= accept;
            peak_o <= shifted_q && (magnitude > threshold_i);
        end
    end

endmodule

// File: rtl/pss_decision.sv
`timescale 1ns/10ps

module pss_decision import pss_pkg::*; (
    input  logic       clk_i,
    input  logic       reset_ni,
    input  logic       sample_valid_i,
    input  logic [2:0] peak_i,
    input  mode_e      mode_i,
    input  nid_t       requested_nid_i,
    output logic       corr_en_o,
    output nid_t       n_id_2_o,
    output logic       detect_valid_o,
    output detect_t    detect_o
);

    sindex_t sample_cnt_q;
    sindex_t peak_index_q;
    logic one_peak;
    nid_t peak_nid;
    logic fire;

    // free-running count of samples since reset
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            sample_cnt_q <= '0;
        end else if (sample_valid_i) begin
            sample_cnt_q <= sample_cnt_q + 1'b1;
        end
    end

    // zero-based index of the sample behind the current peak_i
    always_ff @(posedge clk_i) begin
        peak_index_q <= sample_cnt_q - 1'b1;
    end

    assign one_peak = (peak_i == 3'b001) || (peak_i == 3'b010) || (peak_i == 3'b100);
    assign peak_nid = peak_i[2] ? 2'd2 : (peak_i[1] ? 2'd1 : 2'd0);

    // ------------------------------------------------------------------------
    // mode handling
    // ------------------------------------------------------------------------
    always_comb begin
        case (mode_i)
            SEARCH: begin
                corr_en_o = 1'b1;
                fire = one_peak;
            end
            FIND: begin
                corr_en_o = 1'b1;
                fire = one_peak && (peak_nid == requested_nid_i);
            end
            default: begin
                corr_en_o = 1'b0;
                fire = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            detect_valid_o <= 1'b0;
            n_id_2_o <= '0;
        end else begin
            detect_valid_o <= fire;
            if (fire) begin
                n_id_2_o <= peak_nid;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (fire) begin
            detect_o <= {peak_nid, peak_index_q};
        end
    end

endmodule

// File: rtl/pss_detector_top.sv
`timescale 1ns/10ps

module pss_detector_top import pss_pkg::*; #(
    parameter int PSS_LEN = DEFAULT_PSS_LEN,
    parameter int FIFO_DEPTH = DEFAULT_FIFO_DEPTH
) (
    input  logic     clk_i,
    input  logic     reset_ni,
    input  sample_t  sample_i_i,
    input  sample_t  sample_q_i,
    input  logic     sample_valid_i,
    input  logic     wb_cyc_i,
    input  logic     wb_stb_i,
    input  logic     wb_we_i,
    input  wb_addr_t wb_adr_i,
    input  wb_data_t wb_dat_i,
    output wb_data_t wb_dat_o,
    output logic     wb_ack_o,
    output nid_t     n_id_2_o,
    output logic     n_id_2_valid_o
);

    localparam int LEVEL_W = $clog2(FIFO_DEPTH + 1);

    logic [2:0] peak;
    logic corr_en;
    corr_t threshold;
    mode_e mode;
    nid_t requested_nid;
    detect_t detect;
    detect_t fifo_data;
    logic [LEVEL_W-1:0] fifo_level;
    logic fifo_overflow;
    logic fifo_pop;
    logic clear_overflow;

    // one correlator per N_id_2
    for (genvar n = 0; n < 3; n++) begin : g_corr
        pss_correlator #(
            .PSS_LEN(PSS_LEN),
            .N_ID_2(n)
        ) u_pss_correlator (
            .clk_i(clk_i),
            .reset_ni(reset_ni),
            .sample_i_i(sample_i_i),
            .sample_q_i(sample_q_i),
            .sample_valid_i(sample_valid_i),
            .corr_en_i(corr_en),
            .threshold_i(threshold),
            .peak_o(peak[n])
        );
    end

    pss_decision u_pss_decision (
        .clk_i(clk_i),
        .reset_ni(reset_ni),
        .sample_valid_i(sample_valid_i),
        .peak_i(peak),
        .mode_i(mode),
        .requested_nid_i(requested_nid),
        .corr_en_o(corr_en),
        .n_id_2_o(n_id_2_o),
        .detect_valid_o(n_id_2_valid_o),
        .detect_o(detect)
    );

    detect_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_detect_fifo (
        .clk_i(clk_i),
        .reset_ni(reset_ni),
        .push_i(n_id_2_valid_o),
        .data_i(detect),
        .pop_i(fifo_pop),
        .data_o(fifo_data),
        .level_o(fifo_level),
        .overflow_o(fifo_overflow),
        .clear_overflow_i(clear_overflow)
    );

    pss_regs #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_pss_regs (
        .clk_i(clk_i),
        .reset_ni(reset_ni),
        .wb_cyc_i(wb_cyc_i),
        .wb_stb_i(wb_stb_i),
        .wb_we_i(wb_we_i),
        .wb_adr_i(wb_adr_i),
        .wb_dat_i(wb_dat_i),
        .wb_dat_o(wb_dat_o),
        .wb_ack_o(wb_ack_o),
        .peak_i(peak),
        .fifo_data_i(fifo_data),
        .fifo_level_i(fifo_level),
        .fifo_overflow_i(fifo_overflow),
        .pop_o(fifo_pop),
        .clear_overflow_o(clear_overflow),
        .mode_o(mode),
        .requested_nid_o(requested_nid),
        .threshold_o(threshold)
    );

endmodule

// File: rtl/pss_pkg.sv
package pss_pkg;

    // ------------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------------
    typedef logic signed [7:0] sample_t;
    typedef logic [15:0] corr_t;
    typedef logic [1:0] nid_t;
    typedef logic [13:0] sindex_t;
    // nid_t in the upper bits, sindex_t below
    typedef logic [15:0] detect_t;
    typedef logic [15:0] count_t;
    typedef logic [3:0] wb_addr_t;
    typedef logic [15:0] wb_data_t;

    typedef enum logic [1:0] {
        SEARCH = 2'd0,
        FIND   = 2'd1,
        PAUSE  = 2'd2
    } mode_e;

    // ------------------------------------------------------------------------
    // defaults
    // ------------------------------------------------------------------------
    localparam int DEFAULT_PSS_LEN = 16;
    localparam int DEFAULT_FIFO_DEPTH = 8;
    // a full 16-tap match at amplitude 8 on I and Q gives 256
    localparam corr_t DEFAULT_THRESHOLD = 16'd224;

    // ------------------------------------------------------------------------
    // register map, word addresses
    // ------------------------------------------------------------------------
    localparam wb_addr_t REG_CTRL = 4'd0;
    localparam wb_addr_t REG_THRESH = 4'd1;
    localparam wb_addr_t REG_STATUS = 4'd2;
    localparam wb_addr_t REG_EVENT = 4'd3;
    localparam wb_addr_t REG_CNT0 = 4'd4;
    localparam wb_addr_t REG_CNT1 = 4'd5;
    localparam wb_addr_t REG_CNT2 = 4'd6;

    // ------------------------------------------------------------------------
    // tap sequences, bit j set is +1, clear is -1
    // ------------------------------------------------------------------------
    // low 16 bits differ pairwise in 6, 11 and 13 positions
    localparam logic [31:0] PSS_TAPS_0 = 32'hC5E2_3A59;
    localparam logic [31:0] PSS_TAPS_1 = 32'h1B76_6C1D;
    localparam logic [31:0] PSS_TAPS_2 = 32'h72AD_95E3;

endpackage

// File: rtl/pss_regs.sv
`timescale 1ns/10ps

module pss_regs import pss_pkg::*; #(
    parameter int FIFO_DEPTH = DEFAULT_FIFO_DEPTH
) (
    input  logic                              clk_i,
    input  logic                              reset_ni,
    input  logic                              wb_cyc_i,
    input  logic                              wb_stb_i,
    input  logic                              wb_we_i,
    input  wb_addr_t                          wb_adr_i,
    input  wb_data_t                          wb_dat_i,
    output wb_data_t                          wb_dat_o,
    output logic                              wb_ack_o,
    input  logic [2:0]                        peak_i,
    input  detect_t                           fifo_data_i,
    input  logic [$clog2(FIFO_DEPTH+1)-1:0]   fifo_level_i,
    input  logic                              fifo_overflow_i,
    output logic                              pop_o,
    output logic                              clear_overflow_o,
    output mode_e                             mode_o,
    output nid_t                              requested_nid_o,
    output corr_t                             threshold_o
);

    localparam int LEVEL_W = $clog2(FIFO_DEPTH + 1);

    count_t cnt_q [3];
    wb_data_t rd_data;
    logic wb_req;
    logic wb_wr;
    logic wb_rd;

    // new request while no ack is pending
    assign wb_req = wb_cyc_i && wb_stb_i && !wb_ack_o;
    assign wb_wr = wb_req && wb_we_i;
    assign wb_rd = wb_req && !wb_we_i;

    // side effects of reads land on the edge that raises ack
    assign pop_o = wb_rd && (wb_adr_i == REG_EVENT);
    assign clear_overflow_o = wb_rd && (wb_adr_i == REG_STATUS);

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= wb_req;
        end
    end

    // ------------------------------------------------------------------------
    // control and threshold
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            mode_o <= SEARCH;
            requested_nid_o <= '0;
            threshold_o <= DEFAULT_THRESHOLD;
        end else if (wb_wr) begin
            case (wb_adr_i)
                REG_CTRL: begin
                    mode_o <= mode_e'(wb_dat_i[1:0]);
                    requested_nid_o <= wb_dat_i[3:2];
                end
                REG_THRESH: threshold_o <= wb_dat_i;
                default: ;
            endcase
        end
    end

    // saturating peak counters
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            for (int n = 0; n < 3; n++) begin
                cnt_q[n] <= '0;
            end
        end else begin
            for (int n = 0; n < 3; n++) begin
                if (peak_i[n] && (cnt_q[n] != '1)) begin
                    cnt_q[n] <= cnt_q[n] + 1'b1;
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // read path
    // ------------------------------------------------------------------------
    always_comb begin
        rd_data = '0;
        case (wb_adr_i)
            REG_CTRL: rd_data[3:0] = {requested_nid_o, mode_o};
            REG_THRESH: rd_data = threshold_o;
            REG_STATUS: begin
                rd_data[LEVEL_W-1:0] = fifo_level_i;
                rd_data[15] = fifo_overflow_i;
            end
            REG_EVENT: rd_data = (fifo_level_i != '0) ? fifo_data_i : '0;
            REG_CNT0: rd_data = cnt_q[0];
            REG_CNT1: rd_data = cnt_q[1];
            REG_CNT2: rd_data = cnt_q[2];
            default: ;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (wb_rd) begin
            wb_dat_o <= rd_data;
        end
    end

endmodule

// File: run.sh
#!/usr/bin/env bash
# build and run the PSS detector testbench with Verilator
cd "$(dirname "$0")" || exit 1
mkdir -p build

verilator --binary --timing --assert -Wno-fatal -Mdir build/obj -o pss_sim \
    --top-module pss_detector_tb -f files.f > build/compile.log 2>&1 \
    || { cat build/compile.log; echo "compile failed"; exit 1; }

build/obj/pss_sim > build/sim.log 2>&1
sim_status=$?
cat build/sim.log

grep -q "Checks failed" build/sim.log && { echo "simulation failed"; exit 1; }
[ "$sim_status" -eq 0 ] || { echo "simulator exited with status $sim_status"; exit 1; }
grep -q "All checks passed" build/sim.log || { echo "no pass message in the log"; exit 1; }
echo "simulation passed"

// File: testbench/pss_detector_assert.sv
`timescale 1ns/10ps

module pss_detector_assert import pss_pkg::*; (
    input logic  clk_i,
    input logic  reset_ni,
    input logic  wb_ack_i,
    input logic  n_id_2_valid_i,
    input mode_e mode_i
);

    ack_single: assert property (
        @(posedge clk_i) disable iff (!reset_ni) wb_ack_i |=> !wb_ack_i
    ) else $error("wb_ack_o stayed high for two cycles");

    pulse_single: assert property (
        @(posedge clk_i) disable iff (!reset_ni) n_id_2_valid_i |=> !n_id_2_valid_i
    ) else $error("n_id_2_valid_o stayed high for two cycles");

    // the pulse follows the mode of the cycle before
    pause_quiet: assert property (
        @(posedge clk_i) disable iff (!reset_ni) (mode_i == PAUSE) |=> !n_id_2_valid_i
    ) else $error("detection fired in PAUSE mode");

endmodule

bind pss_detector_top pss_detector_assert u_pss_detector_assert (
    .clk_i(clk_i),
    .reset_ni(reset_ni),
    .wb_ack_i(wb_ack_o),
    .n_id_2_valid_i(n_id_2_valid_o),
    .mode_i(mode)
);

// File: testbench/pss_detector_tb.sv
`timescale 1ns/10ps

module pss_detector_tb import pss_pkg::*; ();

    localparam int PSS_LEN = 16;
    localparam int FIFO_DEPTH = 8;
    localparam int ACK_TIMEOUT = 8;
    localparam int DETECT_TIMEOUT = 16;

    logic clk;
    logic reset_n;
    sample_t sample_i;
    sample_t sample_q;
    logic sample_valid;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    wb_addr_t wb_adr;
    wb_data_t wb_dat_w;
    wb_data_t wb_dat_r;
    logic wb_ack;
    nid_t n_id_2;
    logic n_id_2_valid;

    int checks;
    int errors;
    int test_errors;
    int pulse_cnt;
    int pulse_base;
    int expected_pulses;
    string test_name;

    pss_detector_top #(
        .PSS_LEN(PSS_LEN),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_pss_detector_top (
        .clk_i(clk),
        .reset_ni(reset_n),
        .sample_i_i(sample_i),
        .sample_q_i(sample_q),
        .sample_valid_i(sample_valid),
        .wb_cyc_i(wb_cyc),
        .wb_stb_i(wb_stb),
        .wb_we_i(wb_we),
        .wb_adr_i(wb_adr),
        .wb_dat_i(wb_dat_w),
        .wb_dat_o(wb_dat_r),
        .wb_ack_o(wb_ack),
        .n_id_2_o(n_id_2),
        .n_id_2_valid_o(n_id_2_valid)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // every detection pulse, counted away from the active edge
    always @(negedge clk) begin
        if (reset_n && n_id_2_valid) begin
            pulse_cnt = pulse_cnt + 1;
        end
    end

    task automatic value_mismatch(input string msg);
        $display("Fail at %0t: %s", $time, msg);
        errors++;
        test_errors++;
    endtask

    task automatic report_problem(input string msg);
        $display("%s", msg);
        errors++;
        test_errors++;
    endtask

    // ------------------------------------------------------------------------
    // sample stream
    // ------------------------------------------------------------------------
    task automatic drive_sample(input int i, input int q);
        @(posedge clk);
        #1;
        sample_i = sample_t'(i);
        sample_q = sample_t'(q);
        sample_valid = 1'b1;
    endtask

    task automatic end_samples();
        @(posedge clk);
        #1;
        sample_valid = 1'b0;
        sample_i = '0;
        sample_q = '0;
    endtask

    // zero padding, then tap 0 first so it ends up as the oldest sample
    task automatic send_sequence(input logic [31:0] taps, input int amp, input int pad);
        for (int j = 0; j < pad; j++) begin
            drive_sample(0, 0);
        end
        for (int j = 0; j < PSS_LEN; j++) begin
            if (taps[j]) begin
                drive_sample(amp, amp);
            end else begin
                drive_sample(-amp, -amp);
            end
        end
        end_samples();
    endtask

    task automatic send_zeros(input int count);
        for (int j = 0; j < count; j++) begin
            drive_sample(0, 0);
        end
        end_samples();
    endtask

    // ------------------------------------------------------------------------
    // Wishbone master
    // ------------------------------------------------------------------------
    task automatic wb_access(input logic we, input wb_addr_t adr, input wb_data_t wdata,
                             output wb_data_t rdata, output logic acked);
        int cyc;
        acked = 1'b0;
        rdata = '0;
        cyc = 0;
        @(posedge clk);
        #1;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = we;
        wb_adr = adr;
        wb_dat_w = wdata;
        while (!acked && cyc < ACK_TIMEOUT) begin
            @(posedge clk);
            #1;
            cyc++;
            if (wb_ack) begin
                acked = 1'b1;
                rdata = wb_dat_r;
            end
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
    endtask

    task automatic wb_write(input wb_addr_t adr, input wb_data_t data);
        wb_data_t rdata;
        logic acked;
        wb_access(1'b1, adr, data, rdata, acked);
        checks++;
        if (!acked) begin
            report_problem($sformatf("no Wishbone ack for a write to address %0d", adr));
        end
    endtask

    task automatic wb_read(input wb_addr_t adr, input wb_data_t expected);
        wb_data_t rdata;
        logic acked;
        wb_access(1'b0, adr, '0, rdata, acked);
        checks++;
        if (!acked) begin
            report_problem($sformatf("no Wishbone ack for a read of address %0d", adr));
        end else if (rdata !== expected) begin
            value_mismatch($sformatf("address %0d read %h, expected %h", adr, rdata, expected));
        end
    endtask

    // ------------------------------------------------------------------------
    // detection checks
    // ------------------------------------------------------------------------
    task automatic expect_detection(input int nid, input int cycles);
        int cyc;
        logic seen;
        cyc = 0;
        seen = 1'b0;
        expected_pulses++;
        checks++;
        while (!seen && cyc < DETECT_TIMEOUT) begin
            @(posedge clk);
            #1;
            cyc++;
            if (n_id_2_valid) begin
                seen = 1'b1;
            end
        end
        if (!seen) begin
            report_problem($sformatf("no detection of N_id_2 %0d within %0d cycles",
                                     nid, DETECT_TIMEOUT));
        end else if (cyc != cycles) begin
            value_mismatch($sformatf("detection after %0d cycles, expected %0d", cyc, cycles));
        end else if (n_id_2 !== nid_t'(nid)) begin
            value_mismatch($sformatf("detected N_id_2 %0d, expected %0d", n_id_2, nid));
        end
    endtask

    task automatic expect_quiet(input int window);
        logic flagged;
        flagged = 1'b0;
        checks++;
        for (int cyc = 0; cyc < window; cyc++) begin
            @(posedge clk);
            #1;
            if (n_id_2_valid && !flagged) begin
                value_mismatch($sformatf("unexpected detection of N_id_2 %0d", n_id_2));
                flagged = 1'b1;
            end
        end
    endtask

    task automatic finish_test();
        // one more cycle so the pulse monitor has seen the last pulse
        @(posedge clk);
        #1;
        checks++;
        if (pulse_cnt - pulse_base != expected_pulses) begin
            value_mismatch($sformatf("%0d detections in test, expected %0d",
                                     pulse_cnt - pulse_base, expected_pulses));
        end
        if (test_errors == 0) begin
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: %0d errors", test_name, test_errors);
        end
    endtask

    task automatic run_command(input string line);
        string cmd;
        int n;
        int a;
        int b;
        logic [31:0] h1;
        logic [31:0] h2;
        n = $sscanf(line, "%s", cmd);
        if (n >= 1 && cmd != "#") begin
            if (cmd == "T") begin
                n = $sscanf(line, "%s %s", cmd, test_name);
                test_errors = 0;
                expected_pulses = 0;
                pulse_base = pulse_cnt;
            end else if (cmd == "S") begin
                n = $sscanf(line, "%s %d %d", cmd, a, b);
                drive_sample(a, b);
                end_samples();
            end else if (cmd == "P") begin
                n = $sscanf(line, "%s %h %d %d", cmd, h1, a, b);
                send_sequence(h1, a, b);
            end else if (cmd == "Z") begin
                n = $sscanf(line, "%s %d", cmd, a);
                send_zeros(a);
            end else if (cmd == "W") begin
                n = $sscanf(line, "%s %h %h", cmd, h1, h2);
                wb_write(wb_addr_t'(h1), wb_data_t'(h2));
            end else if (cmd == "R") begin
                n = $sscanf(line, "%s %h %h", cmd, h1, h2);
                wb_read(wb_addr_t'(h1), wb_data_t'(h2));
            end else if (cmd == "D") begin
                n = $sscanf(line, "%s %d %d", cmd, a, b);
                expect_detection(a, b);
            end else if (cmd == "N") begin
                n = $sscanf(line, "%s %d", cmd, a);
                expect_quiet(a);
            end else if (cmd == "E") begin
                finish_test();
            end else begin
                report_problem($sformatf("unknown command %s in the test file", cmd));
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------
    initial begin
        int fd;
        int code;
        string line;
        checks = 0;
        errors = 0;
        test_errors = 0;
        pulse_cnt = 0;
        pulse_base = 0;
        expected_pulses = 0;
        test_name = "none";
        reset_n = 1'b0;
        sample_i = '0;
        sample_q = '0;
        sample_valid = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        repeat (5) @(posedge clk);
        #1;
        reset_n = 1'b1;

        fd = $fopen("testbench/pss_tests.txt", "r");
        if (fd == 0) begin
            report_problem("could not open testbench/pss_tests.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                code = $fgets(line, fd);
                if (code > 0) begin
                    run_command(line);
                end
            end
            $fclose(fd);
        end

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0 && checks > 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: testbench/pss_tests.txt
# T name | S i q | P taps_hex amp pad | Z count | W addr_hex data_hex | R addr_hex expect_hex
# D nid cycles | N window | E ends a test; sample index counts every valid sample
# search: sequences end at sample 31, 63 and 95
T search
P 3a59 8 16
D 0 2
P 6c1d 8 16
D 1 2
P 95e3 8 16
D 2 2
Z 20
S 1 -1
S 0 0
N 8
E
# events: three records queued, then an empty read
T events
R 2 0003
R 3 001f
R 2 0002
R 3 403f
R 2 0001
R 3 805f
R 2 0000
R 3 0000
E
# find with requested N_id_2 of 1, sequence 1 ends at sample 181
T find
W 0 0005
R 0 0005
P 3a59 8 16
N 8
P 6c1d 8 16
D 1 2
E
T pause
W 0 0002
P 3a59 8 16
N 8
P 95e3 8 16
N 8
W 0 0000
E
# threshold of 256 hides a full match, detection at sample 309 after restore
T thresh
W 1 0100
R 1 0100
P 3a59 8 16
N 8
W 1 00e0
P 3a59 8 16
D 0 2
E
# two records queued, seven more detections, the last one dropped
T overflow
P 3a59 8 16
D 0 2
P 6c1d 8 16
D 1 2
P 95e3 8 16
D 2 2
P 3a59 8 16
D 0 2
P 6c1d 8 16
D 1 2
P 95e3 8 16
D 2 2
P 3a59 8 16
D 0 2
R 2 8008
R 2 0008
R 3 40b5
R 3 0135
R 3 0155
R 3 4175
R 3 8195
R 3 01b5
R 3 41d5
R 3 81f5
R 3 0000
R 2 0000
E
T counters
R 4 0006
R 5 0004
R 6 0003
E
